// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = mat_coprocessor_tb
FILELIST  = sources.f
SIM_ARGS  = +verilator+error+limit+1000
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG); grep -q "^All tests passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== hdl/fixed_point_mult.sv ====
`timescale 1ns/1ps
`include "mat_config.svh"

module fixed_point_mult (
    input  logic signed [`MAT_DATA_W-1:0]   a,
    input  logic signed [`MAT_DATA_W-1:0]   b,
    output logic        [`MAT_DATA_W-1:0]   product,
    output logic                            saturated
);
    localparam int W = `MAT_DATA_W;
    localparam int F = `MAT_FRAC_BITS;

    localparam logic signed [2*W-1:0] HALF    = (2*W)'(1 << (F - 1));
    localparam logic signed [2*W-1:0] MAX_VAL = (2*W)'((1 << (W - 1)) - 1);
    localparam logic signed [2*W-1:0] MIN_VAL = (2*W)'(-(1 << (W - 1)));

    logic signed [2*W-1:0] full;
    logic signed [2*W-1:0] rounded;
    logic signed [2*W-1:0] scaled;

    assign full    = a * b;
    assign rounded = full + HALF;      // Ties go toward plus infinity.
    assign scaled  = rounded >>> F;

    always_comb begin
        saturated = 1'b0;
        product   = scaled[W-1:0];
        if (scaled > MAX_VAL) begin
            saturated = 1'b1;
            product   = MAX_VAL[W-1:0];
        end else if (scaled < MIN_VAL) begin
            saturated = 1'b1;
            product   = MIN_VAL[W-1:0];
        end
    end

endmodule

// ==== hdl/mat_cmd_decode.sv ====
`timescale 1ns/1ps
`include "mat_config.svh"

module mat_cmd_decode (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        cmd_strobe,
    input  mat_types_pkg::mat_cmd_u     cmd_word,
    input  logic                        engine_busy,
    output logic                        start,
    output logic [`MAT_DIM_W-1:0]       rows,
    output logic [`MAT_DIM_W-1:0]       cols,
    output logic [`MAT_ADDR_W-1:0]      src1_base,
    output logic [`MAT_ADDR_W-1:0]      src2_base,
    output logic [`MAT_ADDR_W-1:0]      dest_base,
    output logic                        cmd_error
);
    import mat_types_pkg::*;

    mat_opcode_e opcode;

    assign opcode = cmd_word.cfg.opcode; // Same bits in either view.

    always_ff @(posedge clk) begin
        if (reset) begin
            start     <= 1'b0;
            cmd_error <= 1'b0;
            rows      <= `MAT_DIM_W'(1);
            cols      <= `MAT_DIM_W'(1);
            src1_base <= '0;
            src2_base <= '0;
            dest_base <= '0;
        end else begin
            start     <= 1'b0;
            cmd_error <= 1'b0;
            if (cmd_strobe) begin
                case (opcode)
                    OP_CONFIG: begin
                        rows      <= cmd_word.cfg.rows;
                        cols      <= cmd_word.cfg.cols;
                        dest_base <= cmd_word.cfg.dest_base;
                    end
                    OP_RUN: begin
                        if (!engine_busy) begin // Dropped while a job is running.
                            src1_base <= cmd_word.run.src1_base;
                            src2_base <= cmd_word.run.src2_base;
                            start     <= 1'b1;
                        end
                    end
                    OP_ILLEGAL: cmd_error <= 1'b1;
                    default: ;
                endcase
            end
        end
    end

endmodule

// ==== hdl/mat_coprocessor.sv ====
`timescale 1ns/1ps
`include "mat_config.svh"

module mat_coprocessor (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        cmd_strobe,
    input  mat_types_pkg::mat_cmd_u     cmd_word,
    input  logic                        host_we,
    input  logic                        host_sel,
    input  logic [`MAT_ADDR_W-1:0]      host_addr,
    input  logic [`MAT_DATA_W-1:0]      host_wdata,
    input  logic [`MAT_ADDR_W-1:0]      host_raddr,
    output logic [`MAT_DATA_W-1:0]      host_rdata,
    output logic                        busy,
    output logic                        done,
    output logic                        cmd_error,
    output logic [15:0]                 sat_count
);
    import mat_types_pkg::*;
    import mat_mem_pkg::*;

    logic                       start;
    logic                       engine_busy;
    logic [`MAT_DIM_W-1:0]      rows;
    logic [`MAT_DIM_W-1:0]      cols;
    logic [`MAT_ADDR_W-1:0]     src1_base;
    logic [`MAT_ADDR_W-1:0]     src2_base;
    logic [`MAT_ADDR_W-1:0]     dest_base;

    mem_req_t       eng_src1_req, eng_src2_req, status_dest_req;
    mem_req_t       src1_req, src2_req, dest_req;
    mem_rsp_t       src1_rsp, src2_rsp, dest_rsp;
    mat_product_t   product;

    // Covers the start cycle through the done cycle.
    assign busy = start | engine_busy | done;

    always_comb begin
        if (busy) begin
            src1_req = eng_src1_req;
            src2_req = eng_src2_req;
            dest_req = status_dest_req;
        end else begin
            src1_req = '{we: host_we && !host_sel, addr: host_addr, wdata: host_wdata};
            src2_req = '{we: host_we && host_sel, addr: host_addr, wdata: host_wdata};
            dest_req = '{we: 1'b0, addr: host_raddr, wdata: '0};
        end
    end

    assign host_rdata = dest_rsp.rdata;

    mat_cmd_decode u_decode (
        .clk         (clk),
        .reset       (reset),
        .cmd_strobe  (cmd_strobe),
        .cmd_word    (cmd_word),
        .engine_busy (busy),
        .start       (start),
        .rows        (rows),
        .cols        (cols),
        .src1_base   (src1_base),
        .src2_base   (src2_base),
        .dest_base   (dest_base),
        .cmd_error   (cmd_error)
    );

    mat_elementwise_engine u_engine (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .rows      (rows),
        .cols      (cols),
        .src1_base (src1_base),
        .src2_base (src2_base),
        .dest_base (dest_base),
        .src1_req  (eng_src1_req),
        .src2_req  (eng_src2_req),
        .src1_rsp  (src1_rsp),
        .src2_rsp  (src2_rsp),
        .product   (product),
        .busy      (engine_busy)
    );

    mat_status_unit u_status (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .product   (product),
        .dest_req  (status_dest_req),
        .done      (done),
        .sat_count (sat_count)
    );

    mat_scratch_ram #(.DEPTH(`MAT_MEM_DEPTH)) u_src1_ram (
        .clk (clk),
        .req (src1_req),
        .rsp (src1_rsp)
    );

    mat_scratch_ram #(.DEPTH(`MAT_MEM_DEPTH)) u_src2_ram (
        .clk (clk),
        .req (src2_req),
        .rsp (src2_rsp)
    );

    mat_scratch_ram #(.DEPTH(`MAT_MEM_DEPTH)) u_dest_ram (
        .clk (clk),
        .req (dest_req),
        .rsp (dest_rsp)
    );

endmodule

// ==== hdl/mat_elementwise_engine.sv ====
`timescale 1ns/1ps
`include "mat_config.svh"

module mat_elementwise_engine (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        start,
    input  logic [`MAT_DIM_W-1:0]       rows,
    input  logic [`MAT_DIM_W-1:0]       cols,
    input  logic [`MAT_ADDR_W-1:0]      src1_base,
    input  logic [`MAT_ADDR_W-1:0]      src2_base,
    input  logic [`MAT_ADDR_W-1:0]      dest_base,
    output mat_mem_pkg::mem_req_t       src1_req,
    output mat_mem_pkg::mem_req_t       src2_req,
    input  mat_mem_pkg::mem_rsp_t       src1_rsp,
    input  mat_mem_pkg::mem_rsp_t       src2_rsp,
    output mat_types_pkg::mat_product_t product,
    output logic                        busy
);

    // Issue stage.
    logic                       issuing;
    logic [`MAT_DIM_W-1:0]      row_cnt;
    logic [`MAT_DIM_W-1:0]      col_cnt;
    logic [`MAT_DIM_W-1:0]      rows_last;
    logic [`MAT_DIM_W-1:0]      cols_last;
    logic [`MAT_ADDR_W-1:0]     src1_addr;
    logic [`MAT_ADDR_W-1:0]     src2_addr;
    logic [`MAT_ADDR_W-1:0]     issue_dest;
    logic                       issue_last;

    // Read stage, aligned with the RAM output.
    logic                       rd_valid;
    logic                       rd_last;
    logic [`MAT_ADDR_W-1:0]     rd_dest;

    // Product stage.
    logic                       prod_valid;
    logic                       prod_last;
    logic [`MAT_ADDR_W-1:0]     prod_dest;
    logic [`MAT_DATA_W-1:0]     prod_data;
    logic                       prod_sat;

    logic [`MAT_DATA_W-1:0]     mult_out;
    logic                       mult_sat;

    assign issue_last = (row_cnt == rows_last) && (col_cnt == cols_last);

    // Sources are only ever read.
    assign src1_req = '{we: 1'b0, addr: src1_addr, wdata: '0};
    assign src2_req = '{we: 1'b0, addr: src2_addr, wdata: '0};

    always_ff @(posedge clk) begin
        if (reset) begin
            issuing   <= 1'b0;
            row_cnt   <= '0;
            col_cnt   <= '0;
            rows_last <= '0;
            cols_last <= '0;
            busy      <= 1'b0;
        end else if (start) begin
            issuing   <= 1'b1;
            row_cnt   <= '0;
            col_cnt   <= '0;
            rows_last <= rows - 1'b1;
            cols_last <= cols - 1'b1;
            busy      <= 1'b1;
        end else begin
            if (issuing) begin
                if (issue_last) begin
                    issuing <= 1'b0;
                end else if (col_cnt == cols_last) begin // Row-major walk.
                    col_cnt <= '0;
                    row_cnt <= row_cnt + 1'b1;
                end else begin
                    col_cnt <= col_cnt + 1'b1;
                end
            end
            if (prod_valid && prod_last)
                busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            src1_addr  <= src1_base;
            src2_addr  <= src2_base;
            issue_dest <= dest_base;
        end else if (issuing) begin
            src1_addr  <= src1_addr + 1'b1;
            src2_addr  <= src2_addr + 1'b1;
            issue_dest <= issue_dest + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid   <= 1'b0;
            rd_last    <= 1'b0;
            prod_valid <= 1'b0;
            prod_last  <= 1'b0;
        end else begin
            rd_valid   <= issuing;
            rd_last    <= issuing && issue_last;
            prod_valid <= rd_valid;
            prod_last  <= rd_last;
        end
    end

    always_ff @(posedge clk) begin
        rd_dest   <= issue_dest;
        prod_dest <= rd_dest;
        prod_data <= mult_out;
        prod_sat  <= mult_sat;
    end

    fixed_point_mult u_mult (
        .a         (src1_rsp.rdata),
        .b         (src2_rsp.rdata),
        .product   (mult_out),
        .saturated (mult_sat)
    );

    assign product = '{valid: prod_valid, dest: prod_dest, data: prod_data,
                       saturated: prod_sat, last: prod_last};

endmodule

// ==== hdl/mat_mem_pkg.sv ====
`include "mat_config.svh"

package mat_mem_pkg;

    // One access per cycle; a read happens on every cycle at addr.
    typedef struct packed {
        logic                       we;
        logic [`MAT_ADDR_W-1:0]     addr;
        logic [`MAT_DATA_W-1:0]     wdata;
    } mem_req_t;

    typedef struct packed {
        logic [`MAT_DATA_W-1:0]     rdata;
    } mem_rsp_t;

endpackage

// ==== hdl/mat_scratch_ram.sv ====
`timescale 1ns/1ps
`include "mat_config.svh"

module mat_scratch_ram #(
    parameter int DEPTH = `MAT_MEM_DEPTH
) (
    input  logic                    clk,
    input  mat_mem_pkg::mem_req_t   req,
    output mat_mem_pkg::mem_rsp_t   rsp
);

    logic [`MAT_DATA_W-1:0] mem [DEPTH];

    // Read returns the old word when the same address is written.
    always_ff @(posedge clk) begin
        if (req.we)
            mem[req.addr] <= req.wdata;
        rsp.rdata <= mem[req.addr];
    end

endmodule

// ==== hdl/mat_status_unit.sv ====
`timescale 1ns/1ps
`include "mat_config.svh"

module mat_status_unit (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        start,
    input  mat_types_pkg::mat_product_t product,
    output mat_mem_pkg::mem_req_t       dest_req,
    output logic                        done,
    output logic [15:0]                 sat_count
);

    logic                       wr_en;
    logic [`MAT_ADDR_W-1:0]     wr_addr;
    logic [`MAT_DATA_W-1:0]     wr_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_en     <= 1'b0;
            done      <= 1'b0;
            sat_count <= '0;
        end else begin
            wr_en <= product.valid;
            done  <= product.valid && product.last; // Same cycle as the final write.
            if (start)
                sat_count <= '0;
            else if (product.valid && product.saturated)
                sat_count <= sat_count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        wr_addr <= product.dest;
        wr_data <= product.data;
    end

    assign dest_req = '{we: wr_en, addr: wr_addr, wdata: wr_data};

endmodule

// ==== hdl/mat_types_pkg.sv ====
`include "mat_config.svh"

package mat_types_pkg;

    typedef enum logic [1:0] {
        OP_NOP     = 2'b00,
        OP_CONFIG  = 2'b01,
        OP_RUN     = 2'b10,
        OP_ILLEGAL = 2'b11
    } mat_opcode_e;

    localparam int CMD_W         = 32;
    localparam int CFG_PAD_W     = CMD_W - 2 - 2 * `MAT_DIM_W - `MAT_ADDR_W;
    localparam int RUN_PAD_W     = CMD_W - 2 - 2 * `MAT_ADDR_W;

    typedef struct packed {
        mat_opcode_e                opcode;
        logic [`MAT_DIM_W-1:0]      rows;
        logic [`MAT_DIM_W-1:0]      cols;
        logic [`MAT_ADDR_W-1:0]     dest_base;
        logic [CFG_PAD_W-1:0]       pad;
    } mat_cfg_cmd_t;

    typedef struct packed {
        mat_opcode_e                opcode;
        logic [`MAT_ADDR_W-1:0]     src1_base;
        logic [`MAT_ADDR_W-1:0]     src2_base;
        logic [RUN_PAD_W-1:0]       pad;
    } mat_run_cmd_t;

    // Opcode sits in the same top bits of both views.
    typedef union packed {
        mat_cfg_cmd_t cfg;
        mat_run_cmd_t run;
    } mat_cmd_u;

    typedef struct packed {
        logic                       valid;
        logic [`MAT_ADDR_W-1:0]     dest;
        logic [`MAT_DATA_W-1:0]     data;
        logic                       saturated;
        logic                       last;
    } mat_product_t;

endpackage

// ==== include/mat_config.svh ====
`ifndef MAT_CONFIG_SVH
`define MAT_CONFIG_SVH

// Q8.8 element format and scratch memory geometry.
`define MAT_ADDR_W     12
`define MAT_DATA_W     16
`define MAT_DIM_W      6
`define MAT_FRAC_BITS  8
`define MAT_MEM_DEPTH  4096

`endif

// ==== sources.f ====
+incdir+include
hdl/mat_types_pkg.sv
hdl/mat_mem_pkg.sv
hdl/fixed_point_mult.sv
hdl/mat_scratch_ram.sv
hdl/mat_cmd_decode.sv
hdl/mat_elementwise_engine.sv
hdl/mat_status_unit.sv
hdl/mat_coprocessor.sv
tests/mat_asserts.sv
tests/mat_checker.sv
tests/mat_coprocessor_tb.sv

// ==== tests/mat_asserts.sv ====
`timescale 1ns/1ps

module mat_asserts (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        start,
    input  logic                        busy,
    input  mat_mem_pkg::mem_req_t       src1_req,
    input  mat_mem_pkg::mem_req_t       src2_req,
    input  mat_types_pkg::mat_product_t product
);

    int fail_count; // Read by the testbench at the end of the run.

    start_while_busy: assert property (@(posedge clk) disable iff (reset)
        !(start && busy))
        else begin
            fail_count++;
            $error("start arrived while the engine was busy");
        end

    source_write: assert property (@(posedge clk) disable iff (reset)
        !src1_req.we && !src2_req.we)
        else begin
            fail_count++;
            $error("write enable raised on a source memory");
        end

    // First product leaves three cycles after start.
    valid_without_start: assert property (@(posedge clk) disable iff (reset)
        $rose(product.valid) |-> $past(start, 3))
        else begin
            fail_count++;
            $error("product valid rose with no start before it");
        end

endmodule

bind mat_elementwise_engine mat_asserts u_asserts (
    .clk      (clk),
    .reset    (reset),
    .start    (start),
    .busy     (busy),
    .src1_req (src1_req),
    .src2_req (src2_req),
    .product  (product)
);

// ==== tests/mat_checker.sv ====
`timescale 1ns/1ps
`include "mat_config.svh"

module mat_checker (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        cmd_strobe,
    input  mat_types_pkg::mat_cmd_u     cmd_word,
    input  logic                        busy,
    input  logic                        done,
    input  logic                        cmd_error,
    input  logic [15:0]                 sat_count,
    input  logic [`MAT_ADDR_W-1:0]      host_raddr,
    input  logic [`MAT_DATA_W-1:0]      host_rdata,
    input  logic [3:0]                  test_id,
    input  logic                        exp_valid,
    input  logic [`MAT_DATA_W-1:0]      exp_data,
    input  logic                        sat_check,
    input  logic [15:0]                 exp_sat_count,
    output int                          data_errors,
    output int                          proto_errors
);
    import mat_types_pkg::*;

    int                     cyc;
    int                     run_edge;
    int                     run_n;
    int                     cfg_n;
    logic                   have_run;
    logic                   err_pend;
    logic                   rd_pend;
    logic                   exp_busy;
    logic                   exp_done;
    logic [`MAT_ADDR_W-1:0] rd_addr;
    logic [`MAT_DATA_W-1:0] rd_exp;

    function automatic string test_name(input logic [3:0] id);
        case (id)
            4'd1: return "random_4x4";
            4'd2: return "placement";
            4'd3: return "saturation";
            4'd4: return "rounding";
            4'd5: return "cmd_rules";
            default: return "setup";
        endcase
    endfunction

    // Outputs seen at a rising edge are those of the cycle that edge closes.
    always @(posedge clk) begin
        if (reset) begin
            cyc          = 0;
            run_edge     = 0;
            run_n        = 0;
            cfg_n        = 1;
            have_run     = 1'b0;
            err_pend     = 1'b0;
            rd_pend      = 1'b0;
            data_errors  = 0;
            proto_errors = 0;
        end else begin
            cyc      = cyc + 1;
            exp_busy = have_run && cyc > run_edge && cyc <= run_edge + run_n + 4;
            exp_done = have_run && cyc == run_edge + run_n + 4;
            if (busy !== exp_busy) begin
                proto_errors++;
                $display("FAILED %s: busy in cycle %0d of run, expected %b actual %b",
                         test_name(test_id), cyc - run_edge, exp_busy, busy);
            end
            if (done !== exp_done) begin
                proto_errors++;
                $display("FAILED %s: done in cycle %0d of run, expected %b actual %b",
                         test_name(test_id), cyc - run_edge, exp_done, done);
            end
            if (cmd_error !== err_pend) begin
                proto_errors++;
                $display("FAILED %s: cmd_error expected %b actual %b",
                         test_name(test_id), err_pend, cmd_error);
            end
            if (sat_check && sat_count !== exp_sat_count) begin
                data_errors++;
                $display("FAILED %s: sat_count expected %0d actual %0d",
                         test_name(test_id), exp_sat_count, sat_count);
            end
            if (rd_pend && host_rdata !== rd_exp) begin
                data_errors++;
                $display("FAILED %s: word at %h expected %h actual %h",
                         test_name(test_id), rd_addr, rd_exp, host_rdata);
            end
            rd_pend  = exp_valid; // Data comes back at the next edge.
            rd_addr  = host_raddr;
            rd_exp   = exp_data;
            err_pend = cmd_strobe && cmd_word.cfg.opcode == OP_ILLEGAL;
            if (cmd_strobe && cmd_word.cfg.opcode == OP_CONFIG)
                cfg_n = int'(cmd_word.cfg.rows) * int'(cmd_word.cfg.cols);
            if (cmd_strobe && cmd_word.cfg.opcode == OP_RUN && !exp_busy) begin
                have_run = 1'b1;
                run_edge = cyc;
                run_n    = cfg_n;
            end
        end
    end

endmodule

// ==== tests/mat_coprocessor_tb.sv ====
`timescale 1ns/1ps
`include "mat_config.svh"

module tb_clock_gen (
    output logic clk
);
    initial clk = 1'b0;
    always #2 clk = ~clk; // 4 ns period.
endmodule

module mat_coprocessor_tb;
    import mat_types_pkg::*;

    localparam int TOTAL_N  = 16 + 1 + 42 + 8 + 8 + 9;
    localparam int NUM_RUNS = 6;
    // Loads take 2N, latency N+4, readback N+3, plus commands and margin.
    localparam int TIMEOUT_CYCLES = 4 * TOTAL_N + 20 * NUM_RUNS + 100;

    localparam logic [15:0] SAT_A [8] = '{16'h7FFF, 16'h8000, 16'h8000, 16'h1000,
                                          16'h0B50, 16'hF000, 16'hF000, 16'h0100};
    localparam logic [15:0] SAT_B [8] = '{16'h7FFF, 16'h7FFF, 16'h8000, 16'h1000,
                                          16'h0B50, 16'h1000, 16'h0800, 16'h7FFF};
    // Ties at +0.5, -0.5, +1.5, -1.5 and a few negative fractions.
    localparam logic [15:0] RND_A [8] = '{16'h0001, 16'hFFFF, 16'h0001, 16'hFFFF,
                                          16'hFF80, 16'hFF01, 16'h0003, 16'hFE80};
    localparam logic [15:0] RND_B [8] = '{16'h0080, 16'h0080, 16'h0180, 16'h0180,
                                          16'h0080, 16'h0003, 16'h0055, 16'h0101};

    logic                   clk;
    logic                   reset;
    logic                   cmd_strobe;
    mat_cmd_u               cmd_word;
    logic                   host_we;
    logic                   host_sel;
    logic [11:0]            host_addr;
    logic [11:0]            host_raddr;
    logic [15:0]            host_wdata;
    logic [15:0]            host_rdata;
    logic                   busy;
    logic                   done;
    logic                   cmd_error;
    logic [15:0]            sat_count;
    logic [3:0]             test_id;
    logic                   exp_valid;
    logic [15:0]            exp_data;
    logic                   sat_check;
    logic [15:0]            exp_sat_count;
    int                     data_errors;
    int                     proto_errors;
    int                     assert_fails;
    int                     cycles;
    logic [31:0]            lcg_state;
    logic [15:0]            src1_model [`MAT_MEM_DEPTH];
    logic [15:0]            src2_model [`MAT_MEM_DEPTH];
    logic [15:0]            dest_model [`MAT_MEM_DEPTH];
    logic                   known [`MAT_MEM_DEPTH];

    tb_clock_gen u_clock (.clk(clk));

    mat_coprocessor DUT (
        .clk (clk), .reset (reset), .cmd_strobe (cmd_strobe), .cmd_word (cmd_word),
        .host_we (host_we), .host_sel (host_sel), .host_addr (host_addr),
        .host_wdata (host_wdata), .host_raddr (host_raddr), .host_rdata (host_rdata),
        .busy (busy), .done (done), .cmd_error (cmd_error), .sat_count (sat_count)
    );

    mat_checker u_checker (
        .clk (clk), .reset (reset), .cmd_strobe (cmd_strobe), .cmd_word (cmd_word),
        .busy (busy), .done (done), .cmd_error (cmd_error), .sat_count (sat_count),
        .host_raddr (host_raddr), .host_rdata (host_rdata), .test_id (test_id),
        .exp_valid (exp_valid), .exp_data (exp_data), .sat_check (sat_check),
        .exp_sat_count (exp_sat_count), .data_errors (data_errors),
        .proto_errors (proto_errors)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Returns {saturated, value}. Rounds half up, then clamps to Q8.8.
    function automatic logic [16:0] ref_mult(input logic [15:0] a, input logic [15:0] b);
        longint p;
        p = longint'($signed(a)) * longint'($signed(b));
        p = (p + longint'(1 << (`MAT_FRAC_BITS - 1))) >>> `MAT_FRAC_BITS;
        if (p > 32767)
            return {1'b1, 16'h7FFF};
        if (p < -32768)
            return {1'b1, 16'h8000};
        return {1'b0, p[15:0]};
    endfunction

    function automatic mat_cmd_u cfg_cmd(input int rows, input int cols, input logic [11:0] dst);
        mat_cmd_u w;
        w               = '0;
        w.cfg.opcode    = OP_CONFIG;
        w.cfg.rows      = 6'(rows);
        w.cfg.cols      = 6'(cols);
        w.cfg.dest_base = dst;
        return w;
    endfunction

    function automatic mat_cmd_u run_cmd(input logic [11:0] s1, input logic [11:0] s2);
        mat_cmd_u w;
        w               = '0;
        w.run.opcode    = OP_RUN;
        w.run.src1_base = s1;
        w.run.src2_base = s2;
        return w;
    endfunction

    function automatic mat_cmd_u illegal_cmd();
        mat_cmd_u w;
        w            = '0;
        w.cfg.opcode = OP_ILLEGAL;
        return w;
    endfunction

    task automatic write_src(input logic sel, input logic [11:0] addr, input logic [15:0] data);
        @(negedge clk);
        host_we    = 1'b1;
        host_sel   = sel;
        host_addr  = addr;
        host_wdata = data;
        if (sel)
            src2_model[addr] = data;
        else
            src1_model[addr] = data;
    endtask

    task automatic send_cmd(input mat_cmd_u w);
        @(negedge clk);
        host_we    = 1'b0;
        cmd_word   = w;
        cmd_strobe = 1'b1;
        @(negedge clk);
        cmd_strobe = 1'b0;
    endtask

    // Small values, about plus or minus 8.0, so that no product clamps.
    task automatic load_random(input logic [11:0] s1, input logic [11:0] s2, input int n);
        for (int k = 0; k < n; k++) begin
            lcg_state = lcg_next(lcg_state);
            write_src(1'b0, 12'(s1 + k), {{4{lcg_state[27]}}, lcg_state[27:16]});
            lcg_state = lcg_next(lcg_state);
            write_src(1'b1, 12'(s2 + k), {{4{lcg_state[27]}}, lcg_state[27:16]});
        end
    endtask

    task automatic load_table(input logic [11:0] base, input logic [15:0] a [8],
                              input logic [15:0] b [8]);
        for (int k = 0; k < 8; k++) begin
            write_src(1'b0, 12'(base + k), a[k]);
            write_src(1'b1, 12'(base + k), b[k]);
        end
    endtask

    task automatic read_region(input logic [11:0] lo, input int count);
        for (int k = 0; k < count; k++) begin
            @(negedge clk);
            sat_check  = 1'b0;
            host_raddr = 12'(lo + k);
            exp_valid  = known[host_raddr]; // Never-written words are skipped.
            exp_data   = dest_model[host_raddr];
        end
        @(negedge clk);
        exp_valid = 1'b0;
    endtask

    task automatic run_job(input int rows, input int cols, input logic [11:0] s1,
                           input logic [11:0] s2, input logic [11:0] dst, input logic interfere);
        int          n;
        int          nsat;
        logic [16:0] r;
        logic [11:0] a;
        n    = rows * cols;
        nsat = 0;
        for (int k = 0; k < n; k++) begin
            r             = ref_mult(src1_model[12'(s1 + k)], src2_model[12'(s2 + k)]);
            a             = 12'(dst + k);
            dest_model[a] = r[15:0];
            known[a]      = 1'b1;
            if (r[16])
                nsat++;
        end
        send_cmd(cfg_cmd(rows, cols, dst));
        send_cmd(run_cmd(s1, s2));
        if (interfere)
            send_cmd(run_cmd(12'h000, 12'h000)); // Lands while busy.
        do
            @(negedge clk);
        while (done !== 1'b1);
        @(negedge clk); // Last write has landed and busy is low.
        sat_check     = 1'b1;
        exp_sat_count = 16'(nsat);
        read_region(12'(dst - 1), n + 2);
    endtask

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        reset         = 1'b1;
        cmd_strobe    = 1'b0;
        cmd_word      = '0;
        host_we       = 1'b0;
        host_sel      = 1'b0;
        host_addr     = '0;
        host_wdata    = '0;
        host_raddr    = '0;
        test_id       = 4'd0;
        exp_valid     = 1'b0;
        exp_data      = '0;
        sat_check     = 1'b0;
        exp_sat_count = '0;
        lcg_state     = 32'h5c51c4ce;
        for (int i = 0; i < `MAT_MEM_DEPTH; i++)
            known[i] = 1'b0;
        repeat (5) @(negedge clk);
        reset = 1'b0;

        test_id = 4'd1;
        load_random(12'h000, 12'h000, 16);
        run_job(4, 4, 12'h000, 12'h000, 12'h2F0, 1'b0);

        // The 1x1 result sits just above the 6x7 region, test 1 just below.
        test_id = 4'd2;
        load_random(12'h0F0, 12'h0F0, 1);
        run_job(1, 1, 12'h0F0, 12'h0F0, 12'h32A, 1'b0);
        load_random(12'h040, 12'h080, 42);
        run_job(6, 7, 12'h040, 12'h080, 12'h300, 1'b0);

        test_id = 4'd3;
        load_table(12'h100, SAT_A, SAT_B);
        run_job(2, 4, 12'h100, 12'h100, 12'h400, 1'b0);

        test_id = 4'd4;
        load_table(12'h140, RND_A, RND_B);
        run_job(2, 4, 12'h140, 12'h140, 12'h440, 1'b0);

        test_id = 4'd5;
        load_random(12'h180, 12'h180, 9);
        send_cmd(illegal_cmd());
        run_job(3, 3, 12'h180, 12'h180, 12'h500, 1'b1);

        repeat (3) @(negedge clk);
        assert_fails = DUT.u_engine.u_asserts.fail_count;
        $display("Errors: %0d data, %0d protocol, %0d assertion", data_errors, proto_errors,
                 assert_fails);
        if (data_errors + proto_errors + assert_fails == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule
